//--- verilog/nnPkg.sv
package nnPkg;

	// ======================================================================
	// sizes
	// ======================================================================

	localparam int WORD_BITS = 32;
	localparam int NUM_FEATURES = 8;
	localparam int BANK_NEURONS = 3;
	localparam int NUM_HIDDEN = 2 * BANK_NEURONS; // both banks side by side
	localparam int NUM_CLASSES = 4;
	localparam int CLASS_BITS = 2;

	// ======================================================================
	// data types
	// ======================================================================

	typedef logic signed [WORD_BITS-1:0] wordT;

	typedef wordT [NUM_FEATURES-1:0] featureVecT;

	typedef struct packed {
		wordT [BANK_NEURONS-1:0] bankA;
		wordT [BANK_NEURONS-1:0] bankB;
	} hiddenVecT;

	typedef wordT [NUM_CLASSES-1:0] scoreVecT;

	typedef struct packed {
		logic [CLASS_BITS-1:0] classIdx;
		wordT topScore;
	} classResultT;

	// activation is bits 28 to 13 of the sum
	typedef struct packed {
		logic sign;
		logic [1:0] guard;
		logic [15:0] activation;
		logic [12:0] fraction;
	} accumFieldsT;

	typedef union packed {
		wordT raw;
		accumFieldsT fields;
	} accumT;

	typedef wordT [NUM_FEATURES-1:0] featureWeightsT;
	typedef wordT [NUM_HIDDEN-1:0] hiddenWeightsT;

	// ======================================================================
	// default weights and biases
	// ======================================================================

	localparam featureWeightsT [BANK_NEURONS-1:0] BANK_A_WEIGHTS = '{
		'{ 3105, -2214,  4471,  -987,  1562, -3390,  2748,   611},
		'{-1873,  5206,  -642,  2935, -4107,  1288, -2519,  3847},
		'{ 2466,  1034, -3781,  4592,   772, -1655,  3309, -2890}
	};
	localparam wordT [BANK_NEURONS-1:0] BANK_A_BIAS = '{-256, 1024, -512};

	localparam featureWeightsT [BANK_NEURONS-1:0] BANK_B_WEIGHTS = '{
		'{-4022,  1917,  2683,  -735,  3551,   908, -2176,  1440},
		'{ 1329, -3048,  1765,  4218, -1196,  2603,   489, -3725},
		'{ 5012,   734, -2341, -1609,  2877, -4466,  1952,   856}
	};
	localparam wordT [BANK_NEURONS-1:0] BANK_B_BIAS = '{768, -384, -1280};

	localparam hiddenWeightsT [NUM_CLASSES-1:0] CLASS_WEIGHTS = '{
		'{ 2531, -1478,  3902, -2267,  1184,   649},
		'{-1730,  2864,  -915,  3377, -2041,  1526},
		'{  889,  3146,  1672, -2805,  2419, -1357},
		'{ 3613, -2092, -1138,  1845,   777,  2988}
	};
	localparam wordT [NUM_CLASSES-1:0] CLASS_BIAS = '{-512, 256, -1024, 128};

endpackage

//--- verilog/neuronMac.sv
module neuronMac import nnPkg::*; #(
	parameter int FAN_IN = NUM_FEATURES,
	parameter wordT [FAN_IN-1:0] WEIGHTS = '0,
	parameter wordT BIAS = '0
) (
	input logic clk,
	input logic reset,
	input wordT [FAN_IN-1:0] inputs,
	output wordT activation
);

	wordT [FAN_IN-1:0] inputReg;
	wordT [FAN_IN-1:0] products;
	wordT sumNext;
	accumT sumReg;

	// ======================================================================
	// multiply and accumulate
	// ======================================================================

	always_comb
	begin
		for (int i = 0; i < FAN_IN; i++)
		begin
			products[i] = inputReg[i] * WEIGHTS[i]; // only the low word of the product is kept
		end
	end

	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + products[i]; // wraps at the word width, no saturation
		end
	end

	// ======================================================================
	// pipeline registers
	// ======================================================================

	// stage 1 holds the inputs
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputReg <= '0;
		end
		else
		begin
			inputReg <= inputs;
		end
	end

	// stage 2 holds the biased sum
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg.raw <= sumNext;
		end
	end

	// stage 3 holds the rectified activation
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activation <= '0;
		end
		else if (sumReg.fields.sign)
		begin
			activation <= '0; // negative sums clamp to zero
		end
		else
		begin
			activation <= wordT'(sumReg.fields.activation); // zero extended
		end
	end

	// a non-negative sum below 2**29 comes out as the sum divided by 8192
	activationScaled: assert property (@(posedge clk)
		!reset && sumReg.raw >= 0 && sumReg.raw < 32'sh2000_0000
		|=> activation == $past(sumReg.raw >>> 13))
		else $error("activation of %m does not match its sum");

endmodule

//--- verilog/hiddenBank.sv
module hiddenBank import nnPkg::*; #(
	parameter featureWeightsT [BANK_NEURONS-1:0] WEIGHTS = '0,
	parameter wordT [BANK_NEURONS-1:0] BIAS = '0
) (
	input logic clk,
	input logic reset,
	input featureVecT features,
	output wordT [BANK_NEURONS-1:0] activations
);

	// ======================================================================
	// one neuron per weight row, all fed from the same features
	// ======================================================================

	for (genvar n = 0; n < BANK_NEURONS; n++)
	begin : gNeuron
		neuronMac #(
			.FAN_IN(NUM_FEATURES),
			.WEIGHTS(WEIGHTS[n]),
			.BIAS(BIAS[n])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inputs(features),
			.activation(activations[n])
		);
	end

endmodule

//--- verilog/classifierStage.sv
module classifierStage import nnPkg::*; #(
	parameter hiddenWeightsT [NUM_CLASSES-1:0] WEIGHTS = '0,
	parameter wordT [NUM_CLASSES-1:0] BIAS = '0
) (
	input logic clk,
	input logic reset,
	input hiddenVecT hidden,
	output scoreVecT scores,
	output classResultT result
);

	hiddenWeightsT hiddenFlat;
	logic [CLASS_BITS-1:0] bestIdx;
	wordT bestScore;

	// bank A fills indices 0 to 2 and bank B fills 3 to 5
	assign hiddenFlat = {hidden.bankB, hidden.bankA};

	// ======================================================================
	// output neurons
	// ======================================================================

	for (genvar c = 0; c < NUM_CLASSES; c++)
	begin : gOutput
		neuronMac #(
			.FAN_IN(NUM_HIDDEN),
			.WEIGHTS(WEIGHTS[c]),
			.BIAS(BIAS[c])
		) neuron (
			.clk(clk),
			.reset(reset),
			.inputs(hiddenFlat),
			.activation(scores[c])
		);
	end

	// ======================================================================
	// highest score selection
	// ======================================================================

	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int c = 1; c < NUM_CLASSES; c++)
		begin
			if (scores[c] > bestScore) // strict compare keeps the lower index on a tie
			begin
				bestIdx = CLASS_BITS'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.classIdx <= bestIdx;
			result.topScore <= bestScore;
		end
	end

	// the registered score is at least every score it was chosen from
	for (genvar c = 0; c < NUM_CLASSES; c++)
	begin : gMaxCheck
		topScoreIsMax: assert property (@(posedge clk)
			!reset |=> result.topScore >= $past(scores[c]))
			else $error("topScore %0d is below score %0d", result.topScore, c);

		lowerIndexLoses: assert property (@(posedge clk)
			!reset |=> result.classIdx <= c || $past(scores[c]) < result.topScore)
			else $error("class %0d ties the top score but has a lower index", c);
	end

endmodule

//--- verilog/nnTop.sv
module nnTop import nnPkg::*; #(
	parameter featureWeightsT [BANK_NEURONS-1:0] A_WEIGHTS = BANK_A_WEIGHTS,
	parameter wordT [BANK_NEURONS-1:0] A_BIAS = BANK_A_BIAS,
	parameter featureWeightsT [BANK_NEURONS-1:0] B_WEIGHTS = BANK_B_WEIGHTS,
	parameter wordT [BANK_NEURONS-1:0] B_BIAS = BANK_B_BIAS,
	parameter hiddenWeightsT [NUM_CLASSES-1:0] OUT_WEIGHTS = CLASS_WEIGHTS,
	parameter wordT [NUM_CLASSES-1:0] OUT_BIAS = CLASS_BIAS
) (
	input logic clk,
	input logic reset,
	input featureVecT features,
	output scoreVecT scores,
	output classResultT result
);

	wordT [BANK_NEURONS-1:0] bankAOut;
	wordT [BANK_NEURONS-1:0] bankBOut;
	hiddenVecT hidden;

	// ======================================================================
	// hidden layer
	// ======================================================================

	hiddenBank #(
		.WEIGHTS(A_WEIGHTS),
		.BIAS(A_BIAS)
	) bankA (
		.clk(clk),
		.reset(reset),
		.features(features),
		.activations(bankAOut)
	);

	hiddenBank #(
		.WEIGHTS(B_WEIGHTS),
		.BIAS(B_BIAS)
	) bankB (
		.clk(clk),
		.reset(reset),
		.features(features),
		.activations(bankBOut)
	);

	assign hidden.bankA = bankAOut;
	assign hidden.bankB = bankBOut;

	// ======================================================================
	// output layer
	// ======================================================================

	// scores land 5 edges after the sampling edge and the result one edge later
	classifierStage #(
		.WEIGHTS(OUT_WEIGHTS),
		.BIAS(OUT_BIAS)
	) classifier (
		.clk(clk),
		.reset(reset),
		.hidden(hidden),
		.scores(scores),
		.result(result)
	);

endmodule

//--- dv/nnModel.svh
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// ======================================================================
// random numbers
// ======================================================================

// Galois form of x^32 + x^22 + x^2 + x + 1, one step gives one new bit
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	logic [31:0] next;
	next = state >> 1;
	if (state[0])
	begin
		next = next ^ 32'h8020_0003;
	end
	return next;
endfunction

// ======================================================================
// reference network
// ======================================================================

function automatic wordT rectify(input wordT sum);
	wordT out;
	out = '0;
	if (!sum[31])
	begin
		out[15:0] = sum[28:13]; // bits 28 down to 13, zero extended
	end
	return out;
endfunction

function automatic wordT hiddenNeuron(input featureVecT x, input featureWeightsT w,
		input wordT bias);
	wordT acc;
	acc = bias;
	for (int i = 0; i < NUM_FEATURES; i++)
	begin
		acc = acc + x[i] * w[i]; // low word of each product, sum wraps
	end
	return rectify(acc);
endfunction

function automatic wordT outputNeuron(input hiddenWeightsT x, input hiddenWeightsT w,
		input wordT bias);
	wordT acc;
	acc = bias;
	for (int i = 0; i < NUM_HIDDEN; i++)
	begin
		acc = acc + x[i] * w[i];
	end
	return rectify(acc);
endfunction

// bank A lands in entries 0 to 2 and bank B in 3 to 5
function automatic hiddenWeightsT hiddenOf(input featureVecT f);
	hiddenWeightsT flat;
	for (int n = 0; n < BANK_NEURONS; n++)
	begin
		flat[n] = hiddenNeuron(f, BANK_A_WEIGHTS[n], BANK_A_BIAS[n]);
		flat[BANK_NEURONS+n] = hiddenNeuron(f, BANK_B_WEIGHTS[n], BANK_B_BIAS[n]);
	end
	return flat;
endfunction

function automatic scoreVecT scoresOf(input hiddenWeightsT h);
	scoreVecT s;
	for (int c = 0; c < NUM_CLASSES; c++)
	begin
		s[c] = outputNeuron(h, CLASS_WEIGHTS[c], CLASS_BIAS[c]);
	end
	return s;
endfunction

function automatic classResultT bestClass(input scoreVecT s);
	classResultT best;
	best.classIdx = '0;
	best.topScore = s[0];
	for (int c = 1; c < NUM_CLASSES; c++)
	begin
		if (s[c] > best.topScore) // a tie keeps the lower index
		begin
			best.classIdx = CLASS_BITS'(c);
			best.topScore = s[c];
		end
	end
	return best;
endfunction

`endif

//--- dv/nnTb.sv
module nnTb import nnPkg::*; ();

	`include "nnModel.svh"

	localparam logic [31:0] LFSR_SEED = 32'h0a117bb2;
	localparam int DRAIN_LIMIT = 16;

	logic clk;
	logic reset;
	featureVecT features;
	scoreVecT scores;
	classResultT result;

	logic [31:0] lfsrState;
	int checkCount;

	// one entry per drive edge, front entry is the next one due
	scoreVecT scoreQ[$];
	classResultT resultQ[$];
	string scoreNameQ[$];
	string resultNameQ[$];

	nnTop dut (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// stimulus helpers
	// ======================================================================

	function automatic wordT randomWord(input int bits);
		logic [31:0] word;
		logic [31:0] signFill;
		word = '0;
		for (int i = 0; i < bits; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			word = {word[30:0], lfsrState[0]};
		end
		signFill = 32'hffff_ffff << bits;
		if (word[bits-1])
		begin
			word = word | signFill; // sign extend
		end
		return wordT'(word);
	endfunction

	function automatic featureVecT randomVector(input int bits);
		featureVecT v;
		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			v[i] = randomWord(bits);
		end
		return v;
	endfunction

	function automatic featureVecT negativeVector();
		featureVecT v;
		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			v[i] = randomWord(14);
			if (v[i] > 0)
			begin
				v[i] = -v[i];
			end
		end
		return v;
	endfunction

	// ======================================================================
	// checks
	// ======================================================================

	task automatic failStop();
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic failRun(input string why);
		$display("%s", why);
		failStop();
	endtask

	task automatic checkScores(input string name, input scoreVecT expected,
			input scoreVecT actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s scores expected %h actual %h", name, expected, actual);
			failStop();
		end
		checkCount++;
	endtask

	task automatic checkResult(input string name, input classResultT expected,
			input classResultT actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s result expected idx %0d score %0d actual idx %0d score %0d",
				name, expected.classIdx, expected.topScore, actual.classIdx, actual.topScore);
			failStop();
		end
		checkCount++;
	endtask

	task automatic checkDueOutputs();
		if (scoreQ.size() > 0)
		begin
			checkScores(scoreNameQ.pop_front(), scoreQ.pop_front(), scores);
		end
		if (resultQ.size() > 0)
		begin
			checkResult(resultNameQ.pop_front(), resultQ.pop_front(), result);
		end
	endtask

	// ======================================================================
	// one clock of stimulus and checking
	// ======================================================================

	task automatic stepCycle(input featureVecT f, input logic rst, input string name);
		scoreVecT expScores;
		@(posedge clk);
		if (reset)
		begin
			// the reset sampled here wipes every vector still in flight
			foreach (scoreQ[i]) scoreQ[i] = '0;
			foreach (resultQ[i]) resultQ[i] = '0;
		end
		features <= f;
		reset <= rst;
		expScores = rst ? scoreVecT'('0) : scoresOf(hiddenOf(f));
		scoreQ.push_back(expScores);
		resultQ.push_back(rst ? classResultT'('0) : bestClass(expScores));
		scoreNameQ.push_back(name);
		resultNameQ.push_back(name);
		@(negedge clk);
		checkDueOutputs();
	endtask

	task automatic drainPipeline();
		int cycles;
		cycles = 0;
		while (scoreQ.size() > 0 || resultQ.size() > 0)
		begin
			if (cycles >= DRAIN_LIMIT)
			begin
				failRun("expected outputs were still pending after the drain timeout");
			end
			cycles++;
			@(posedge clk);
			features <= '0;
			@(negedge clk);
			checkDueOutputs();
		end
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================

	initial
	begin
		reset = 1'b1;
		features = '0;
		lfsrState = LFSR_SEED;
		checkCount = 0;
		// outputs before the first vectors are due read as zero
		repeat (6) scoreQ.push_back('0);
		repeat (6) scoreNameQ.push_back("reset");
		repeat (7) resultQ.push_back('0);
		repeat (7) resultNameQ.push_back("reset");

		repeat (10) stepCycle(randomVector(14), 1'b1, "reset");
		repeat (400) stepCycle(randomVector(14), 1'b0, "streaming");
		repeat (8) stepCycle('0, 1'b0, "zero clamp");
		repeat (40) stepCycle(negativeVector(), 1'b0, "ties");
		repeat (100) stepCycle(randomVector(32), 1'b0, "wraparound");
		repeat (20) stepCycle(randomVector(14), 1'b0, "before reset");
		repeat (3) stepCycle(randomVector(14), 1'b1, "mid reset");
		repeat (20) stepCycle(randomVector(14), 1'b0, "after reset");
		drainPipeline();

		if (checkCount > 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			failRun("no outputs were checked");
		end
	end

endmodule

//--- filelist.f
+incdir+dv
verilog/nnPkg.sv
verilog/neuronMac.sv
verilog/hiddenBank.sv
verilog/classifierStage.sv
verilog/nnTop.sv
dv/nnTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the nnTb testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module nnTb -Mdir "$BUILD_DIR" -o nnSim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/nnSim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if grep -q "Test failed" "$LOG_FILE"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation passed"
exit 0
